// ==== bench/rta_host_model.sv ====
/* host memory model for the ray-test accelerator
   serves the DMA read stream and captures the DMA write stream, with stalls */
module rta_host_model #(
  parameter int MEM_LINES = 256
) (
  input  logic                        clk,
  input  logic                        rst_n,
  // stall requests from the testbench
  input  logic                        rd_stall,
  input  logic                        wr_stall,
  // DMA read side
  input  logic                        rd_go,
  input  logic [rta_pkg::ADDR_W-1:0]  rd_addr,
  input  logic [rta_pkg::ADDR_W-1:0]  rd_size,
  input  logic                        rd_en,
  output logic                        rd_empty,
  output logic [rta_pkg::LINE_W-1:0]  rd_data,
  output logic                        rd_done,
  // DMA write side
  input  logic                        wr_go,
  input  logic [rta_pkg::ADDR_W-1:0]  wr_addr,
  input  logic [rta_pkg::ADDR_W-1:0]  wr_size,
  input  logic                        wr_en,
  input  logic [rta_pkg::LINE_W-1:0]  wr_data,
  output logic                        wr_full,
  output logic                        wr_done
);
  timeunit 1ns;
  timeprecision 100ps;
  import rta_pkg::*;

  // host memory in line units, addresses wrap
  logic [LINE_W-1:0] mem [MEM_LINES];
  logic [ADDR_W-1:0] rd_base;
  logic [ADDR_W-1:0] rd_len;
  logic [ADDR_W-1:0] rd_ptr;
  logic              rd_active;
  logic [ADDR_W-1:0] wr_base;
  logic [ADDR_W-1:0] wr_len;
  logic [ADDR_W-1:0] wr_ptr;
  logic              wr_active;

  function automatic int line_index(input logic [ADDR_W-1:0] a);
    return int'(a % MEM_LINES);
  endfunction

  // idle stream levels and an address pattern in every line
  initial begin
    rd_empty = 1'b1;
    rd_data  = '0;
    rd_done  = 1'b0;
    wr_full  = 1'b1;
    wr_done  = 1'b0;
    for (int a = 0; a < MEM_LINES; a++) begin
      mem[a] = {(LINE_W / 8){8'(a)}};
    end
  end

  // ========================================
  // stream bookkeeping on the rising edge
  // ========================================
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_active <= 1'b0;
      rd_ptr    <= '0;
      wr_active <= 1'b0;
      wr_ptr    <= '0;
    end else begin
      // go restarts a stream
      if (rd_go) begin
        rd_active <= 1'b1;
        rd_base   <= rd_addr;
        rd_len    <= rd_size;
        rd_ptr    <= '0;
      end else if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (wr_go) begin
        wr_active <= 1'b1;
        wr_base   <= wr_addr;
        wr_len    <= wr_size;
        wr_ptr    <= '0;
      end else if (wr_en) begin
        // lines land in arrival order
        mem[line_index(wr_base + wr_ptr)] <= wr_data;
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // levels toward the DUT change on the falling edge
  always @(negedge clk) begin
    rd_empty <= !rst_n || !rd_active || rd_stall || (rd_ptr >= rd_len);
    rd_data  <= mem[line_index(rd_base + rd_ptr)];
    rd_done  <= rst_n && rd_active && (rd_ptr >= rd_len);
    wr_full  <= !rst_n || !wr_active || wr_stall || (wr_ptr >= wr_len);
    wr_done  <= rst_n && wr_active && (wr_ptr >= wr_len);
  end

endmodule

// ==== bench/rta_tb.sv ====
/* ray-test accelerator testbench
   MMIO programming, host memory traffic and result checks against a box-hit reference */
module rta_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rta_pkg::*;

  localparam int NUM_RT     = 4;
  localparam int NUM_TRI    = 512;
  localparam int POLL_LIMIT = 400;

  logic               clk;
  logic               rst_n;
  logic               mmio_wr;
  logic               mmio_rd;
  logic [MMIO_AW-1:0] mmio_addr;
  logic [MMIO_DW-1:0] mmio_wr_data;
  logic [MMIO_DW-1:0] mmio_rd_data;
  logic               rd_go;
  logic [ADDR_W-1:0]  rd_addr;
  logic [ADDR_W-1:0]  rd_size;
  logic               rd_en;
  logic               rd_empty;
  logic [LINE_W-1:0]  rd_data;
  logic               rd_done;
  logic               wr_go;
  logic [ADDR_W-1:0]  wr_addr;
  logic [ADDR_W-1:0]  wr_size;
  logic               wr_en;
  logic [LINE_W-1:0]  wr_data;
  logic               wr_full;
  logic               wr_done;
  // stall control toward the host model
  logic               stalls_on;
  logic               rd_stall;
  logic               wr_stall;
  logic [31:0]        lfsr = 32'h165ef150;
  // rays as programmed, used by the reference
  logic [COORD_W-1:0] ray_xs [NUM_RT];
  logic [COORD_W-1:0] ray_ys [NUM_RT];
  int                 value_errors;
  int                 proto_errors;
  int                 timeouts;

  rta #(.NUM_RT(NUM_RT), .NUM_TRI(NUM_TRI)) DUT (
    .clk(clk), .rst_n(rst_n),
    .mmio_wr(mmio_wr), .mmio_rd(mmio_rd), .mmio_addr(mmio_addr),
    .mmio_wr_data(mmio_wr_data), .mmio_rd_data(mmio_rd_data),
    .rd_go(rd_go), .rd_addr(rd_addr), .rd_size(rd_size), .rd_en(rd_en),
    .rd_empty(rd_empty), .rd_data(rd_data), .rd_done(rd_done),
    .wr_go(wr_go), .wr_addr(wr_addr), .wr_size(wr_size), .wr_en(wr_en),
    .wr_data(wr_data), .wr_full(wr_full), .wr_done(wr_done)
  );

  rta_host_model host (
    .clk(clk), .rst_n(rst_n), .rd_stall(rd_stall), .wr_stall(wr_stall),
    .rd_go(rd_go), .rd_addr(rd_addr), .rd_size(rd_size), .rd_en(rd_en),
    .rd_empty(rd_empty), .rd_data(rd_data), .rd_done(rd_done),
    .wr_go(wr_go), .wr_addr(wr_addr), .wr_size(wr_size), .wr_en(wr_en),
    .wr_data(wr_data), .wr_full(wr_full), .wr_done(wr_done)
  );

  always #50 clk = ~clk;

  // ========================================
  // random source and stalls
  // ========================================
  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // about one cycle in four stalls on each side
  always @(posedge clk) begin
    if (stalls_on) begin
      rd_stall <= (take_bits(2) == 0);
      wr_stall <= (take_bits(2) == 0);
    end else begin
      rd_stall <= 1'b0;
      wr_stall <= 1'b0;
    end
  end

  // FIFO side rules seen from the host
  always @(posedge clk) begin
    if (rst_n) begin
      assert (!(rd_en && rd_empty)) else begin
        proto_errors++;
        $display("rd_en was high while rd_empty was high at %0t", $time);
      end
      assert (!(wr_en && wr_full)) else begin
        proto_errors++;
        $display("wr_en was high while wr_full was high at %0t", $time);
      end
    end
  end

  // ========================================
  // helpers
  // ========================================
  task automatic expect_eq(input string name, input logic [LINE_W-1:0] exp,
                           input logic [LINE_W-1:0] act);
    assert (act === exp) else begin
      value_errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic mmio_write(input logic [MMIO_AW-1:0] addr, input logic [MMIO_DW-1:0] data);
    @(negedge clk);
    mmio_wr      = 1'b1;
    mmio_addr    = addr;
    mmio_wr_data = data;
    @(negedge clk);
    mmio_wr = 1'b0;
  endtask

  // data is registered, so it is taken one cycle after the strobe
  task automatic mmio_read(input logic [MMIO_AW-1:0] addr, output logic [MMIO_DW-1:0] data);
    @(negedge clk);
    mmio_rd   = 1'b1;
    mmio_addr = addr;
    @(negedge clk);
    mmio_rd = 1'b0;
    data    = mmio_rd_data;
  endtask

  task automatic load_rays();
    for (int k = 0; k < NUM_RT; k++) begin
      mmio_write(MMIO_AW'(REG_RAY_BASE + 2 * k), MMIO_DW'({ray_ys[k], ray_xs[k]}));
    end
  endtask

  // record fields from the low end: xmin xmax ymin ymax z
  function automatic logic [LINE_W-1:0] box_rec(input logic [COORD_W-1:0] xmin, xmax,
                                                ymin, ymax, z);
    logic [LINE_W-1:0] rec;
    rec = '0;
    rec[15:0]  = xmin;
    rec[31:16] = xmax;
    rec[47:32] = ymin;
    rec[63:48] = ymax;
    rec[79:64] = z;
    return rec;
  endfunction

  // small coordinates and depths so hits and ties happen often
  task automatic load_random(input int base, input int count);
    logic [COORD_W-1:0] x0;
    logic [COORD_W-1:0] y0;
    logic [COORD_W-1:0] w;
    logic [COORD_W-1:0] h;
    logic [COORD_W-1:0] z;
    for (int i = 0; i < count; i++) begin
      x0 = COORD_W'(take_bits(6));
      w  = COORD_W'(take_bits(5));
      y0 = COORD_W'(take_bits(6));
      h  = COORD_W'(take_bits(5));
      z  = COORD_W'(take_bits(4));
      host.mem[base + i] = box_rec(x0, x0 + w, y0, y0 + h, z);
    end
    for (int k = 0; k < NUM_RT; k++) begin
      ray_xs[k] = COORD_W'(take_bits(6));
      ray_ys[k] = COORD_W'(take_bits(6));
    end
    load_rays();
  endtask

  // edge hits, an equal-z pair and rays that miss everything
  task automatic load_edge_case(input int base);
    host.mem[base + 0] = box_rec(10, 30, 5, 20, 40);
    host.mem[base + 1] = box_rec(0, 10, 20, 40, 25);
    host.mem[base + 2] = box_rec(10, 10, 20, 20, 25);
    host.mem[base + 3] = box_rec(50, 60, 50, 60, 5);
    ray_xs[0] = 10;
    ray_ys[0] = 20;
    ray_xs[1] = 200;
    ray_ys[1] = 200;
    ray_xs[2] = 55;
    ray_ys[2] = 50;
    ray_xs[3] = 31;
    ray_ys[3] = 21;
    load_rays();
  endtask

  // nearest hit by strict z compare, count of all hits
  function automatic logic [LINE_W-1:0] expected_line(input int k, input int base,
                                                      input int count);
    logic [LINE_W-1:0]  rec;
    logic [LINE_W-1:0]  line;
    logic               hit;
    logic [15:0]        id;
    logic [COORD_W-1:0] z;
    logic [15:0]        cnt;
    hit = 1'b0;
    id  = '0;
    z   = '1;
    cnt = '0;
    for (int i = 0; i < count; i++) begin
      rec = host.mem[base + i];
      if (ray_xs[k] >= rec[15:0] && ray_xs[k] <= rec[31:16] &&
          ray_ys[k] >= rec[47:32] && ray_ys[k] <= rec[63:48]) begin
        cnt++;
        if (!hit || rec[79:64] < z) begin
          id = 16'(i);
          z  = rec[79:64];
        end
        hit = 1'b1;
      end
    end
    line = '0;
    line[0]     = hit;
    line[16:1]  = id;
    line[32:17] = z;
    line[48:33] = cnt;
    return line;
  endfunction

  task automatic wait_done(input string name, output bit ok);
    logic [MMIO_DW-1:0] v;
    int polls;
    ok    = 1'b0;
    polls = 0;
    while (!ok && polls < POLL_LIMIT) begin
      mmio_read(REG_DONE, v);
      ok = v[0];
      polls++;
    end
    if (!ok) begin
      timeouts++;
      $display("timeout in %s, REG_DONE did not read 1 within %0d polls", name, POLL_LIMIT);
    end
  endtask

  // ========================================
  // scenarios
  // ========================================
  task automatic run_trace(input string name, input int tri_base, input int res_base,
                           input int count, output bit ok);
    logic [MMIO_DW-1:0] v;
    // result slots start with their address pattern
    for (int k = 0; k < NUM_RT; k++) begin
      host.mem[res_base + k] = {(LINE_W / 8){8'(res_base + k)}};
    end
    mmio_write(REG_RD_ADDR, MMIO_DW'(tri_base));
    mmio_write(REG_WR_ADDR, MMIO_DW'(res_base));
    mmio_write(REG_TRI_COUNT, MMIO_DW'(count));
    mmio_write(REG_GO, 64'd1);
    // done from the previous run drops with go
    mmio_read(REG_DONE, v);
    expect_eq({name, " done after go"}, '0, LINE_W'(v));
    wait_done(name, ok);
    if (ok) begin
      // stream sizes as requested by the DUT at the go pulses
      expect_eq({name, " read size"}, LINE_W'(count), LINE_W'(host.rd_len));
      expect_eq({name, " write size"}, LINE_W'(NUM_RT), LINE_W'(host.wr_len));
      for (int k = 0; k < NUM_RT; k++) begin
        expect_eq($sformatf("%s core %0d", name, k), expected_line(k, tri_base, count),
                  host.mem[res_base + k]);
      end
    end
  endtask

  task automatic check_registers();
    logic [MMIO_DW-1:0] v;
    mmio_read(REG_DONE, v);
    expect_eq("done after reset", '0, LINE_W'(v));
    mmio_write(REG_RD_ADDR, 64'h1234_5678_9abc_def0);
    mmio_write(REG_WR_ADDR, 64'h0fed_cba9_8765_4321);
    mmio_write(REG_TRI_COUNT, 64'd16);
    for (int k = 0; k < NUM_RT; k++) begin
      ray_xs[k] = COORD_W'(16'h0100 + k);
      ray_ys[k] = COORD_W'(16'h0200 + k);
    end
    load_rays();
    mmio_read(REG_RD_ADDR, v);
    expect_eq("rd_addr readback", LINE_W'(64'h1234_5678_9abc_def0), LINE_W'(v));
    mmio_read(REG_WR_ADDR, v);
    expect_eq("wr_addr readback", LINE_W'(64'h0fed_cba9_8765_4321), LINE_W'(v));
    mmio_read(REG_TRI_COUNT, v);
    expect_eq("tri_count readback", LINE_W'(16), LINE_W'(v));
    for (int k = 0; k < NUM_RT; k++) begin
      mmio_read(MMIO_AW'(REG_RAY_BASE + 2 * k), v);
      expect_eq($sformatf("ray %0d readback", k), LINE_W'({ray_ys[k], ray_xs[k]}),
                LINE_W'(v));
    end
  endtask

  // a timeout ends the sequence early
  task automatic run_scenarios();
    bit ok;
    check_registers();
    load_random(8'h00, 16);
    run_trace("random", 8'h00, 8'h80, 16, ok);
    if (!ok) return;
    load_edge_case(8'h30);
    run_trace("edges", 8'h30, 8'h90, 4, ok);
    if (!ok) return;
    run_trace("empty", 8'h30, 8'ha0, 0, ok);
    if (!ok) return;
    stalls_on = 1'b1;
    load_random(8'h40, 16);
    run_trace("stalled", 8'h40, 8'hb0, 16, ok);
    stalls_on = 1'b0;
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    mmio_wr      = 1'b0;
    mmio_rd      = 1'b0;
    mmio_addr    = '0;
    mmio_wr_data = '0;
    stalls_on    = 1'b0;
    rd_stall     = 1'b0;
    wr_stall     = 1'b0;
    value_errors = 0;
    proto_errors = 0;
    timeouts     = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    run_scenarios();
    $display("value errors %0d, protocol errors %0d, timeouts %0d",
             value_errors, proto_errors, timeouts);
    if (value_errors == 0 && proto_errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
logic/rta_pkg.sv
logic/mem_controller.sv
logic/mem_triangle.sv
logic/rt_core.sv
logic/mem_main.sv
logic/rta.sv
bench/rta_host_model.sv
bench/rta_tb.sv

// ==== logic/mem_controller.sv ====
/* run controller
   MMIO registers plus the load, trace and dump sequence over the DMA streams */
module mem_controller #(
  parameter int  NUM_RT  = 4,
  parameter int  NUM_TRI = 512,
  localparam int TRI_IW  = $clog2(NUM_TRI),
  localparam int TRI_CW  = $clog2(NUM_TRI + 1),
  localparam int RT_AW   = (NUM_RT > 1) ? $clog2(NUM_RT) : 1
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // host MMIO
  input  logic                          mmio_wr,
  input  logic                          mmio_rd,
  input  logic [rta_pkg::MMIO_AW-1:0]   mmio_addr,
  input  logic [rta_pkg::MMIO_DW-1:0]   mmio_wr_data,
  output logic [rta_pkg::MMIO_DW-1:0]   mmio_rd_data,
  // DMA read
  output logic                          rd_go,
  output logic [rta_pkg::ADDR_W-1:0]    rd_addr,
  output logic [rta_pkg::ADDR_W-1:0]    rd_size,
  output logic                          rd_en,
  input  logic                          rd_empty,
  input  logic [rta_pkg::LINE_W-1:0]    rd_data,
  input  logic                          rd_done,
  // DMA write
  output logic                          wr_go,
  output logic [rta_pkg::ADDR_W-1:0]    wr_addr,
  output logic [rta_pkg::ADDR_W-1:0]    wr_size,
  output logic                          wr_en,
  output logic [rta_pkg::LINE_W-1:0]    wr_data,
  input  logic                          wr_full,
  input  logic                          wr_done,
  // triangle memory
  output logic                          tri_we,
  output logic [TRI_IW-1:0]             tri_waddr,
  output logic [rta_pkg::LINE_W-1:0]    tri_wdata,
  output logic                          trace_start,
  output logic [TRI_CW-1:0]             tri_count,
  // cores
  output logic [rta_pkg::COORD_W-1:0]   ray_x [NUM_RT],
  output logic [rta_pkg::COORD_W-1:0]   ray_y [NUM_RT],
  input  logic [NUM_RT-1:0]             core_done,
  // result memory
  output logic                          res_re,
  output logic [RT_AW-1:0]              res_raddr,
  input  logic [rta_pkg::LINE_W-1:0]    res_rdata
);
  import rta_pkg::*;

  localparam int RT_CW = $clog2(NUM_RT + 1);

  mc_state_e            state_q;
  logic [ADDR_W-1:0]    rd_base_q;
  logic [ADDR_W-1:0]    wr_base_q;
  logic [MMIO_DW-1:0]   tri_cnt_q;
  logic [2*COORD_W-1:0] ray_q [NUM_RT];
  logic                 go;
  logic                 done;
  logic [MMIO_AW-1:0]   ray_off;
  logic [RT_AW-1:0]     ray_sel;
  logic                 ray_sel_ok;
  logic [TRI_CW-1:0]    load_cnt_q;
  logic                 load_end;
  logic [NUM_RT-1:0]    seen_q;
  logic                 all_done;
  logic [RT_CW-1:0]     rd_idx_q;
  logic [RT_CW-1:0]     wr_cnt_q;
  logic                 line_vld_q;

  // ========================================
  // register decode
  // ========================================
  assign go      = mmio_wr && (mmio_addr == REG_GO);
  assign done    = (state_q == FINISH);
  assign ray_off = mmio_addr - REG_RAY_BASE;
  assign ray_sel = ray_off[RT_AW:1];
  // even offsets only, one register per core
  assign ray_sel_ok = (mmio_addr >= REG_RAY_BASE) && !ray_off[0] &&
                      (ray_off[MMIO_AW-1:1] < NUM_RT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_base_q <= '0;
      wr_base_q <= '0;
      tri_cnt_q <= '0;
      for (int k = 0; k < NUM_RT; k++) begin
        ray_q[k] <= '0;
      end
    end else if (mmio_wr) begin
      case (mmio_addr)
        REG_RD_ADDR:   rd_base_q <= ADDR_W'(mmio_wr_data);
        REG_WR_ADDR:   wr_base_q <= ADDR_W'(mmio_wr_data);
        REG_TRI_COUNT: tri_cnt_q <= mmio_wr_data;
        default: begin
          if (ray_sel_ok) begin
            ray_q[ray_sel] <= mmio_wr_data[2*COORD_W-1:0];
          end
        end
      endcase
    end
  end

  // read data lands the cycle after mmio_rd
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mmio_rd_data <= '0;
    end else if (mmio_rd) begin
      case (mmio_addr)
        REG_RD_ADDR:   mmio_rd_data <= MMIO_DW'(rd_base_q);
        REG_WR_ADDR:   mmio_rd_data <= MMIO_DW'(wr_base_q);
        REG_TRI_COUNT: mmio_rd_data <= tri_cnt_q;
        REG_DONE:      mmio_rd_data <= MMIO_DW'(done);
        default:       mmio_rd_data <= ray_sel_ok ? MMIO_DW'(ray_q[ray_sel]) : '0;
      endcase
    end
  end

  always_comb begin
    for (int k = 0; k < NUM_RT; k++) begin
      ray_x[k] = ray_q[k][COORD_W-1:0];
      ray_y[k] = ray_q[k][2*COORD_W-1:COORD_W];
    end
  end

  // ========================================
  // stream control
  // ========================================
  assign rd_addr   = rd_base_q;
  assign tri_count = tri_cnt_q[TRI_CW-1:0];
  assign rd_size   = ADDR_W'(tri_count);
  assign wr_addr   = wr_base_q;
  assign wr_size   = ADDR_W'(NUM_RT);

  // take a line the same cycle it is offered
  // hold off during rd_go so a stale stream is not sampled
  assign rd_en     = (state_q == LOAD) && !rd_go && !rd_empty && (load_cnt_q != tri_count);
  assign tri_we    = rd_en;
  assign tri_waddr = load_cnt_q[TRI_IW-1:0];
  assign tri_wdata = rd_data;
  assign load_end  = (load_cnt_q == tri_count) && rd_done && !rd_go;

  // a core_done in the current cycle counts too
  assign all_done = (&(seen_q | core_done)) && !trace_start;

  // result line sits in res_rdata until the write side takes it
  assign wr_en     = (state_q == DUMP) && line_vld_q && !wr_full;
  assign wr_data   = res_rdata;
  assign res_re    = (state_q == DUMP) && (rd_idx_q != RT_CW'(NUM_RT)) &&
                     (!line_vld_q || wr_en);
  assign res_raddr = rd_idx_q[RT_AW-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      rd_go       <= 1'b0;
      wr_go       <= 1'b0;
      trace_start <= 1'b0;
      load_cnt_q  <= '0;
      seen_q      <= '0;
      rd_idx_q    <= '0;
      wr_cnt_q    <= '0;
      line_vld_q  <= 1'b0;
    end else begin
      // go pulses last one cycle
      rd_go       <= 1'b0;
      wr_go       <= 1'b0;
      trace_start <= 1'b0;
      case (state_q)
        IDLE, FINISH: begin
          if (go) begin
            state_q    <= LOAD;
            rd_go      <= 1'b1;
            load_cnt_q <= '0;
          end
        end
        LOAD: begin
          if (rd_en) begin
            load_cnt_q <= load_cnt_q + 1'b1;
          end
          if (load_end) begin
            state_q     <= TRACE;
            trace_start <= 1'b1;
          end
        end
        TRACE: begin
          seen_q <= trace_start ? '0 : (seen_q | core_done);
          if (all_done) begin
            state_q    <= DUMP;
            wr_go      <= 1'b1;
            rd_idx_q   <= '0;
            wr_cnt_q   <= '0;
            line_vld_q <= 1'b0;
          end
        end
        DUMP: begin
          if (res_re) begin
            rd_idx_q <= rd_idx_q + 1'b1;
          end
          if (res_re) begin
            line_vld_q <= 1'b1;
          end else if (wr_en) begin
            line_vld_q <= 1'b0;
          end
          if (wr_en) begin
            wr_cnt_q <= wr_cnt_q + 1'b1;
          end
          if ((wr_cnt_q == RT_CW'(NUM_RT)) && wr_done && !wr_go) begin
            state_q <= FINISH;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // DMA FIFO side rules
  a_rd_en_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
    rd_en |-> !rd_empty);
  a_wr_en_not_full: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> !wr_full);

endmodule

// ==== logic/mem_main.sv ====
/* result memory
   one line per ray core with a single registered read port */
module mem_main #(
  parameter int  NUM_RT = 4,
  localparam int RT_AW  = (NUM_RT > 1) ? $clog2(NUM_RT) : 1
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [NUM_RT-1:0]          res_we,
  input  logic [rta_pkg::LINE_W-1:0] res_line [NUM_RT],
  input  logic                       res_re,
  input  logic [RT_AW-1:0]           res_raddr,
  output logic [rta_pkg::LINE_W-1:0] res_rdata
);
  import rta_pkg::*;

  logic [LINE_W-1:0] lines [NUM_RT];

  // each bank has exactly one writer
  for (genvar k = 0; k < NUM_RT; k++) begin : g_bank
    always_ff @(posedge clk) begin
      if (res_we[k]) begin
        lines[k] <= res_line[k];
      end
    end
  end

  // read data one cycle after res_re
  always_ff @(posedge clk) begin
    if (res_re) begin
      res_rdata <= lines[res_raddr];
    end
  end

  a_raddr_range: assert property (@(posedge clk) disable iff (!rst_n)
    res_re |-> (res_raddr < NUM_RT));

endmodule

// ==== logic/mem_triangle.sv ====
/* triangle record memory
   loaded by the controller, then swept once and broadcast to every core */
module mem_triangle #(
  parameter int  NUM_TRI = 512,
  localparam int TRI_IW  = $clog2(NUM_TRI),
  localparam int TRI_CW  = $clog2(NUM_TRI + 1)
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       tri_we,
  input  logic [TRI_IW-1:0]          tri_waddr,
  input  logic [rta_pkg::LINE_W-1:0] tri_wdata,
  input  logic                       trace_start,
  input  logic [TRI_CW-1:0]          tri_count,
  output logic                       tri_valid,
  output logic [TRI_IW-1:0]          tri_id,
  output logic [rta_pkg::LINE_W-1:0] tri_rec,
  output logic                       tri_last
);
  import rta_pkg::*;

  logic [LINE_W-1:0] mem [NUM_TRI];
  logic              sweep_q;
  logic [TRI_IW-1:0] ptr_q;
  logic [TRI_CW-1:0] count_q;
  logic              last_q;
  logic              rd_now;
  logic [TRI_IW-1:0] rd_addr;
  logic [TRI_CW-1:0] cur_count;
  logic              rd_last;

  // record 0 is read on the trace_start edge itself
  assign rd_now    = trace_start ? (tri_count != '0) : sweep_q;
  assign rd_addr   = trace_start ? '0 : ptr_q;
  assign cur_count = trace_start ? tri_count : count_q;
  assign rd_last   = (TRI_CW'(rd_addr) + TRI_CW'(1)) == cur_count;

  // an empty stream ends right at trace_start
  assign tri_last = last_q || (trace_start && (tri_count == '0));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sweep_q   <= 1'b0;
      ptr_q     <= '0;
      count_q   <= '0;
      last_q    <= 1'b0;
      tri_valid <= 1'b0;
      tri_id    <= '0;
    end else begin
      tri_valid <= rd_now;
      last_q    <= rd_now && rd_last;
      if (trace_start) begin
        count_q <= tri_count;
      end
      if (rd_now) begin
        tri_id  <= rd_addr;
        ptr_q   <= rd_addr + 1'b1;
        sweep_q <= !rd_last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tri_we) begin
      mem[tri_waddr] <= tri_wdata;
    end
    if (rd_now) begin
      tri_rec <= mem[rd_addr];
    end
  end

  a_count_fits: assert property (@(posedge clk) disable iff (!rst_n)
    trace_start |-> (tri_count <= NUM_TRI));

endmodule

// ==== logic/rt_core.sv ====
/* ray core
   box test of each streamed record against one z-axis ray, keeps nearest hit */
module rt_core #(
  parameter int  NUM_TRI = 512,
  localparam int TRI_IW  = $clog2(NUM_TRI)
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [rta_pkg::COORD_W-1:0] ray_x,
  input  logic [rta_pkg::COORD_W-1:0] ray_y,
  input  logic                        trace_start,
  input  logic                        tri_valid,
  input  logic [TRI_IW-1:0]           tri_id,
  input  logic [rta_pkg::LINE_W-1:0]  tri_rec,
  input  logic                        tri_last,
  output logic                        res_we,
  output logic [rta_pkg::LINE_W-1:0]  res_line,
  output logic                        core_done
);
  import rta_pkg::*;

  logic [COORD_W-1:0] xmin;
  logic [COORD_W-1:0] xmax;
  logic [COORD_W-1:0] ymin;
  logic [COORD_W-1:0] ymax;
  logic [COORD_W-1:0] tri_z;
  logic               hit;
  logic               hit_q;
  logic [TRI_IW-1:0]  near_id_q;
  logic [COORD_W-1:0] near_z_q;
  logic [COORD_W-1:0] hit_cnt_q;

  assign xmin  = tri_rec[TRI_XMIN*COORD_W +: COORD_W];
  assign xmax  = tri_rec[TRI_XMAX*COORD_W +: COORD_W];
  assign ymin  = tri_rec[TRI_YMIN*COORD_W +: COORD_W];
  assign ymax  = tri_rec[TRI_YMAX*COORD_W +: COORD_W];
  assign tri_z = tri_rec[TRI_Z*COORD_W +: COORD_W];

  // inclusive edges
  assign hit = (ray_x >= xmin) && (ray_x <= xmax) && (ray_y >= ymin) && (ray_y <= ymax);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hit_q     <= 1'b0;
      near_id_q <= '0;
      near_z_q  <= '1;
      hit_cnt_q <= '0;
    end else if (trace_start) begin
      // back to the miss line
      hit_q     <= 1'b0;
      near_id_q <= '0;
      near_z_q  <= '1;
      hit_cnt_q <= '0;
    end else if (tri_valid && hit) begin
      hit_q     <= 1'b1;
      hit_cnt_q <= hit_cnt_q + 1'b1;
      // strict compare so the earlier id stays on a tie
      if (!hit_q || (tri_z < near_z_q)) begin
        near_id_q <= tri_id;
        near_z_q  <= tri_z;
      end
    end
  end

  // result goes out the cycle after the last record
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_we <= 1'b0;
    end else begin
      res_we <= tri_last;
    end
  end

  assign core_done = res_we;

  always_comb begin
    res_line                      = '0;
    res_line[RES_HIT]             = hit_q;
    res_line[RES_ID +: COORD_W]   = COORD_W'(near_id_q);
    res_line[RES_Z +: COORD_W]    = near_z_q;
    res_line[RES_CNT +: COORD_W]  = hit_cnt_q;
  end

endmodule

// ==== logic/rta.sv ====
/* ray-test accelerator top
   controller, triangle memory, ray cores and result memory */
module rta #(
  parameter int NUM_RT  = 4,
  parameter int NUM_TRI = 512
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          mmio_wr,
  input  logic                          mmio_rd,
  input  logic [rta_pkg::MMIO_AW-1:0]   mmio_addr,
  input  logic [rta_pkg::MMIO_DW-1:0]   mmio_wr_data,
  output logic [rta_pkg::MMIO_DW-1:0]   mmio_rd_data,
  output logic                          rd_go,
  output logic [rta_pkg::ADDR_W-1:0]    rd_addr,
  output logic [rta_pkg::ADDR_W-1:0]    rd_size,
  output logic                          rd_en,
  input  logic                          rd_empty,
  input  logic [rta_pkg::LINE_W-1:0]    rd_data,
  input  logic                          rd_done,
  output logic                          wr_go,
  output logic [rta_pkg::ADDR_W-1:0]    wr_addr,
  output logic [rta_pkg::ADDR_W-1:0]    wr_size,
  output logic                          wr_en,
  output logic [rta_pkg::LINE_W-1:0]    wr_data,
  input  logic                          wr_full,
  input  logic                          wr_done
);
  import rta_pkg::*;

  localparam int TRI_IW = $clog2(NUM_TRI);
  localparam int TRI_CW = $clog2(NUM_TRI + 1);
  localparam int RT_AW  = (NUM_RT > 1) ? $clog2(NUM_RT) : 1;

  // controller to triangle memory
  logic              tri_we;
  logic [TRI_IW-1:0] tri_waddr;
  logic [LINE_W-1:0] tri_wdata;
  logic              trace_start;
  logic [TRI_CW-1:0] tri_count;

  // broadcast triangle stream
  logic              tri_valid;
  logic [TRI_IW-1:0] tri_id;
  logic [LINE_W-1:0] tri_rec;
  logic              tri_last;

  // per-core rays and results
  logic [COORD_W-1:0] ray_x [NUM_RT];
  logic [COORD_W-1:0] ray_y [NUM_RT];
  logic [NUM_RT-1:0]  core_done;
  logic [NUM_RT-1:0]  res_we;
  logic [LINE_W-1:0]  res_line [NUM_RT];

  // result readback
  logic              res_re;
  logic [RT_AW-1:0]  res_raddr;
  logic [LINE_W-1:0] res_rdata;

  mem_controller #(.NUM_RT(NUM_RT), .NUM_TRI(NUM_TRI)) u_ctrl (.*);

  mem_triangle #(.NUM_TRI(NUM_TRI)) u_tri (.*);

  // every core sees the same stream
  for (genvar k = 0; k < NUM_RT; k++) begin : g_core
    rt_core #(.NUM_TRI(NUM_TRI)) u_core (
      .clk        (clk),
      .rst_n      (rst_n),
      .ray_x      (ray_x[k]),
      .ray_y      (ray_y[k]),
      .trace_start(trace_start),
      .tri_valid  (tri_valid),
      .tri_id     (tri_id),
      .tri_rec    (tri_rec),
      .tri_last   (tri_last),
      .res_we     (res_we[k]),
      .res_line   (res_line[k]),
      .core_done  (core_done[k])
    );
  end

  mem_main #(.NUM_RT(NUM_RT)) u_main (.*);

endmodule

// ==== logic/rta_pkg.sv ====
/* ray-test accelerator shared definitions
   widths, controller states, MMIO register map and line layouts */
package rta_pkg;

  // ========================================
  // widths
  // ========================================
  // one cache line for DMA data, triangle records and result lines
  localparam int LINE_W  = 128;
  // coordinates and depth are unsigned
  localparam int COORD_W = 16;
  localparam int ADDR_W  = 64;
  localparam int MMIO_AW = 16;
  localparam int MMIO_DW = 64;

  // controller phases in run order
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    TRACE,
    DUMP,
    FINISH
  } mc_state_e;

  // ========================================
  // register map
  // ========================================
  // 64-bit registers on even word addresses
  typedef enum logic [MMIO_AW-1:0] {
    REG_RD_ADDR   = 16'h0050,
    REG_WR_ADDR   = 16'h0052,
    REG_TRI_COUNT = 16'h0054,
    REG_GO        = 16'h0056,
    REG_DONE      = 16'h0058,
    // ray k lives at REG_RAY_BASE + 2*k with x low and y above it
    REG_RAY_BASE  = 16'h0060
  } mmio_reg_e;

  // triangle record fields in COORD_W units from the lsb
  localparam int TRI_XMIN = 0;
  localparam int TRI_XMAX = 1;
  localparam int TRI_YMIN = 2;
  localparam int TRI_YMAX = 3;
  localparam int TRI_Z    = 4;

  // result line bit offsets
  localparam int RES_HIT = 0;
  localparam int RES_ID  = 1;
  localparam int RES_Z   = 17;
  localparam int RES_CNT = 33;

endpackage
